/* arp_top.f */
+incdir+hdl
hdl/arp_pkg.sv
hdl/eth_rx_parser.sv
hdl/arp_rx.sv
hdl/arp_tx.sv
hdl/arp_regs.sv
hdl/arp_top.sv
sim/arp_chk.sv
sim/arp_tb.sv

/* Bender.yml */
package:
  name: arp_responder

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/arp_pkg.sv
      - hdl/eth_rx_parser.sv
      - hdl/arp_rx.sv
      - hdl/arp_tx.sv
      - hdl/arp_regs.sv
      - hdl/arp_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/arp_chk.sv
      - sim/arp_tb.sv

/* sim/arp_tb.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_tb;

  logic                clk;
  logic                fsm_rst;
  arp_pkg::byte_strm_t rx;
  arp_pkg::byte_strm_t tx;
  logic                tx_rdy;
  arp_pkg::wb_req_t    wb_i;
  arp_pkg::wb_rsp_t    wb_o;

  // reference model state.
  arp_pkg::mac_addr_t  dev_mac;
  arp_pkg::ipv4_addr_t dev_ip;
  int                  exp_req;
  int                  exp_reply;
  int                  exp_drop;
  logic [7:0]          exp_q [$];
  logic [7:0]          got_q [$];
  int                  errors;
  int                  n_pass;
  int                  n_fail;

  arp_top i_arp_top (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx),
    .tx      (tx),
    .tx_rdy  (tx_rdy),
    .wb_i    (wb_i),
    .wb_o    (wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    errors++;
  endtask

  // ************************************************************
  // host bus.
  // ************************************************************
  task automatic wb_access(input logic wr, input logic [2:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(posedge clk);
    wb_i <= '{cyc: 1'b1, stb: 1'b1, we: wr, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_o.ack && n < 16);
    if (!wb_o.ack) timed_out("a bus acknowledge");
    rdat = wb_o.dat;
    @(posedge clk);
    wb_i <= '0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic check_counters();
    logic [31:0] d;
    wb_read(`REG_REQ_CNT, d);
    check("req_cnt", d, exp_req);
    wb_read(`REG_REPLY_CNT, d);
    check("reply_cnt", d, exp_reply);
    wb_read(`REG_DROP_CNT, d);
    check("drop_cnt", d, exp_drop);
  endtask

  // ************************************************************
  // frames and the reply model.
  // ************************************************************
  function automatic arp_pkg::mac_addr_t rand_mac();
    return {16'($urandom), $urandom};
  endfunction

  function automatic arp_pkg::arp_hdr_t make_req(input arp_pkg::mac_addr_t s_mac,
                                                 input arp_pkg::ipv4_addr_t s_ip,
                                                 input arp_pkg::ipv4_addr_t t_ip);
    return '{htype: 16'h0001, ptype: `ARP_PTYPE_IPV4, hlen: 8'd6, plen: 8'd4,
             oper: `ARP_OPER_REQ, sha: s_mac, spa: s_ip, tha: rand_mac(), tpa: t_ip};
  endfunction

  function automatic void push_be(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) exp_q.push_back(v[i*8 +: 8]);
  endfunction

  // reply bytes in wire order, taken field by field from the reply rule.
  function automatic void model_reply(input arp_pkg::mac_addr_t s_mac,
                                      input arp_pkg::ipv4_addr_t s_ip);
    exp_q.delete();
    push_be(s_mac, 6);
    push_be(dev_mac, 6);
    push_be(`ARP_ETHERTYPE, 2);
    push_be(16'h0001, 2);
    push_be(`ARP_PTYPE_IPV4, 2);
    push_be(8'd6, 1);
    push_be(8'd4, 1);
    push_be(`ARP_OPER_REPLY, 2);
    push_be(dev_mac, 6);
    push_be(dev_ip, 4);
    push_be(s_mac, 6);
    push_be(s_ip, 4);
  endfunction

  // len below 42 truncates the frame, above 42 pads it with random bytes.
  task automatic send_frame(input arp_pkg::ethertype_t et, input arp_pkg::arp_hdr_t h,
                            input int len, input int err_at);
    logic [7:0]   b [$];
    logic [111:0] eh;
    eh = {rand_mac(), rand_mac(), et};
    for (int i = 13; i >= 0; i--) b.push_back(eh[i*8 +: 8]);
    for (int i = 27; i >= 0; i--) b.push_back(h[i*8 +: 8]);
    while (b.size() < len) b.push_back(8'($urandom));
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      rx <= '{dat: b[i], val: 1'b1, err: (i == err_at)};
    end
    @(posedge clk);
    rx <= '0;
    repeat (4) @(posedge clk);
  endtask

  task automatic collect_reply();
    int n;
    got_q.delete();
    n = 0;
    while (got_q.size() < `ARP_REPLY_BYTES && n < 600) begin
      @(posedge clk);
      tx_rdy <= ($urandom % 4) != 0;
      @(negedge clk);
      if (tx.val && tx_rdy) begin
        got_q.push_back(tx.dat);
        check("tx.err", tx.err, 1'b0);
      end
      n++;
    end
    @(posedge clk);
    tx_rdy <= 1'b0;
    if (got_q.size() < `ARP_REPLY_BYTES) timed_out("the reply bytes");
  endtask

  task automatic check_reply();
    check("reply length", got_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      if (i < got_q.size()) check($sformatf("reply byte %0d", i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic expect_quiet();
    repeat (12) begin
      @(negedge clk);
      check("tx.val with no reply due", tx.val, 1'b0);
    end
  endtask

  task automatic answer_one(input int len);
    arp_pkg::mac_addr_t  s_mac;
    arp_pkg::ipv4_addr_t s_ip;
    s_mac = rand_mac();
    s_ip  = $urandom;
    model_reply(s_mac, s_ip);
    send_frame(`ARP_ETHERTYPE, make_req(s_mac, s_ip, dev_ip), len, -1);
    exp_req++;
    collect_reply();
    check_reply();
    exp_reply++;
    expect_quiet();
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      n_pass++;
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      n_fail++;
      $display("[%0t ns] %s: %0d errors", $time, name, errors - err0);
    end
  endtask

  // ************************************************************
  // test sequence.
  // ************************************************************
  initial begin
    arp_pkg::arp_hdr_t   h;
    arp_pkg::mac_addr_t  a_mac;
    arp_pkg::ipv4_addr_t a_ip;
    logic [31:0]         d;
    int                  err0;
    int                  k;
    void'($urandom(31438));
    fsm_rst   = 1'b1;
    rx        = '0;
    tx_rdy    = 1'b0;
    wb_i      = '0;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    exp_req   = 0;
    exp_reply = 0;
    exp_drop  = 0;
    repeat (2) @(posedge clk);
    fsm_rst <= 1'b0;

    err0    = errors;
    dev_ip  = $urandom;
    dev_mac = rand_mac();
    wb_write(`REG_IPV4, dev_ip);
    wb_write(`REG_MAC_HI, {16'($urandom), dev_mac[47:32]});
    wb_write(`REG_MAC_LO, dev_mac[31:0]);
    wb_write(`REG_REQ_CNT, $urandom);
    wb_read(`REG_IPV4, d);
    check("ipv4 register", d, dev_ip);
    wb_read(`REG_MAC_HI, d);
    check("mac hi register", d, {16'h0000, dev_mac[47:32]});
    wb_read(`REG_MAC_LO, d);
    check("mac lo register", d, dev_mac[31:0]);
    check_counters();
    wb_read(3'd6, d);
    check("unmapped register", d, 32'h0);
    end_test("registers", err0);

    err0 = errors;
    repeat (6) answer_one(42 + $urandom % 19);
    end_test("replies", err0);

    err0 = errors;
    h = make_req(rand_mac(), $urandom, dev_ip);
    send_frame(16'h0800, h, 42, -1);
    expect_quiet();
    send_frame(`ARP_ETHERTYPE, make_req(rand_mac(), $urandom, dev_ip + 1 + $urandom % 64),
               42, -1);
    expect_quiet();
    h.oper = `ARP_OPER_REPLY;
    send_frame(`ARP_ETHERTYPE, h, 42, -1);
    expect_quiet();
    h.oper = `ARP_OPER_REQ;
    h.hlen = 8'd8;
    send_frame(`ARP_ETHERTYPE, h, 42, -1);
    expect_quiet();
    h.hlen = 8'd6;
    // the short frame completes a request that the frame before it began.
    k = 1 + $urandom % 27;
    send_frame(`ARP_ETHERTYPE, h >> (8 * k), 42, -1);
    expect_quiet();
    send_frame(`ARP_ETHERTYPE, h << (8 * (28 - k)), 14 + k, -1);
    expect_quiet();
    check_counters();
    end_test("non-qualifying frames", err0);

    err0 = errors;
    send_frame(`ARP_ETHERTYPE, make_req(rand_mac(), $urandom, dev_ip), 60, 41 + $urandom % 19);
    expect_quiet();
    send_frame(`ARP_ETHERTYPE, make_req(rand_mac(), $urandom, dev_ip), 61 + $urandom % 10, -1);
    expect_quiet();
    answer_one(42);
    check_counters();
    end_test("aborted frames", err0);

    // the second request lands while the first reply is stalled.
    err0  = errors;
    a_mac = rand_mac();
    a_ip  = $urandom;
    send_frame(`ARP_ETHERTYPE, make_req(a_mac, a_ip, dev_ip), 42, -1);
    send_frame(`ARP_ETHERTYPE, make_req(rand_mac(), $urandom, dev_ip), 42, -1);
    exp_req += 2;
    exp_drop++;
    model_reply(a_mac, a_ip);
    collect_reply();
    check_reply();
    exp_reply++;
    expect_quiet();
    check_counters();
    end_test("drops and counters", err0);

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* sim/arp_chk.sv */
`timescale 1ns/10ps

module arp_chk (
  input logic                clk,
  input logic                fsm_rst,
  input arp_pkg::byte_strm_t tx,
  input logic                tx_rdy,
  input arp_pkg::wb_req_t    wb_i,
  input arp_pkg::wb_rsp_t    wb_o
);

  // ************************************************************
  // transmit stream.
  // ************************************************************
  // a stalled byte stays on the bus until it is taken.
  tx_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    tx.val && !tx_rdy |=> tx.val && $stable(tx.dat))
    else $error("tx byte changed while stalled");

  tx_reset: assert property (@(posedge clk) fsm_rst |=> !tx.val)
    else $error("tx.val high right after reset");

  // ************************************************************
  // wishbone slave.
  // ************************************************************
  ack_cause: assert property (@(posedge clk) disable iff (fsm_rst)
    wb_o.ack |-> $past(wb_i.cyc && wb_i.stb))
    else $error("ack without a bus cycle");

  // one ack per access, even while stb is still high.
  ack_single: assert property (@(posedge clk) disable iff (fsm_rst)
    wb_o.ack |=> !wb_o.ack)
    else $error("ack held for more than one cycle");

endmodule

bind arp_top arp_chk i_arp_chk (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .tx      (tx),
  .tx_rdy  (tx_rdy),
  .wb_i    (wb_i),
  .wb_o    (wb_o)
);

/* hdl/arp_top.sv */
`timescale 1ns/10ps

module arp_top (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::byte_strm_t rx,
  output arp_pkg::byte_strm_t tx,
  input  logic                tx_rdy,
  input  arp_pkg::wb_req_t    wb_i,
  output arp_pkg::wb_rsp_t    wb_o
);

  arp_pkg::byte_strm_t pay;
  arp_pkg::eth_meta_t  meta;
  arp_pkg::dev_t       dev;
  arp_pkg::arp_hdr_t   req_hdr;
  logic                req_pulse;
  logic                reply_pulse;
  logic                drop_pulse;

  eth_rx_parser i_eth_rx_parser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx),
    .pay     (pay),
    .meta    (meta)
  );

  arp_rx i_arp_rx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .pay       (pay),
    .meta      (meta),
    .dev       (dev),
    .req_hdr   (req_hdr),
    .req_pulse (req_pulse)
  );

  arp_tx i_arp_tx (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .req_hdr     (req_hdr),
    .req_pulse   (req_pulse),
    .tx          (tx),
    .tx_rdy      (tx_rdy),
    .reply_pulse (reply_pulse),
    .drop_pulse  (drop_pulse)
  );

  arp_regs i_arp_regs (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .req_pulse   (req_pulse),
    .reply_pulse (reply_pulse),
    .drop_pulse  (drop_pulse),
    .dev         (dev)
  );

endmodule

/* hdl/arp_regs.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_regs (
  input  logic             clk,
  input  logic             fsm_rst,
  input  arp_pkg::wb_req_t wb_i,
  output arp_pkg::wb_rsp_t wb_o,
  input  logic             req_pulse,
  input  logic             reply_pulse,
  input  logic             drop_pulse,
  output arp_pkg::dev_t    dev
);

  logic          ack_q;
  logic [31:0]   rdat_q;
  logic [31:0]   rdat;
  logic          sel;
  arp_pkg::cnt_t req_cnt;
  arp_pkg::cnt_t reply_cnt;
  arp_pkg::cnt_t drop_cnt;

  function automatic arp_pkg::cnt_t sat_inc(input arp_pkg::cnt_t c, input logic ev);
    sat_inc = (ev && c != '1) ? c + 16'd1 : c;
  endfunction

  // a new access is taken only while ack is low, so ack lasts one cycle.
  assign sel = wb_i.cyc && wb_i.stb && !ack_q;

  // ************************************************************
  // bus access and address registers.
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      ack_q <= 1'b0;
      dev   <= '0;
    end else begin
      ack_q <= sel;
      if (sel && wb_i.we) begin
        case (wb_i.adr)
          `REG_IPV4:   dev.ipv4       <= wb_i.dat;
          `REG_MAC_HI: dev.mac[47:32] <= wb_i.dat[15:0];
          `REG_MAC_LO: dev.mac[31:0]  <= wb_i.dat;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (wb_i.adr)
      `REG_IPV4:      rdat = dev.ipv4;
      `REG_MAC_HI:    rdat = {16'h0000, dev.mac[47:32]};
      `REG_MAC_LO:    rdat = dev.mac[31:0];
      `REG_REQ_CNT:   rdat = {16'h0000, req_cnt};
      `REG_REPLY_CNT: rdat = {16'h0000, reply_cnt};
      `REG_DROP_CNT:  rdat = {16'h0000, drop_cnt};
      default:        rdat = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sel) rdat_q <= rdat;
  end

  assign wb_o = '{ack: ack_q, dat: rdat_q};

  // ************************************************************
  // event counters that stop at full scale.
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      req_cnt   <= '0;
      reply_cnt <= '0;
      drop_cnt  <= '0;
    end else begin
      req_cnt   <= sat_inc(req_cnt, req_pulse);
      reply_cnt <= sat_inc(reply_cnt, reply_pulse);
      drop_cnt  <= sat_inc(drop_cnt, drop_pulse);
    end
  end

endmodule

/* hdl/arp_tx.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_tx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::arp_hdr_t   req_hdr,
  input  logic                req_pulse,
  output arp_pkg::byte_strm_t tx,
  input  logic                tx_rdy,
  output logic                reply_pulse,
  output logic                drop_pulse
);

  localparam int LAST = `ARP_REPLY_BYTES - 1;

  arp_pkg::tx_state_t                 state;
  logic [5:0]                         idx;
  arp_pkg::mac_addr_t                 req_sha;
  arp_pkg::ipv4_addr_t                req_spa;
  arp_pkg::eth_meta_t                 eth;
  arp_pkg::arp_hdr_t                  rep;
  logic [`ARP_REPLY_BYTES-1:0][7:0]   frame;
  logic                               busy;
  logic                               xfer;
  logic                               last;

  // ************************************************************
  // reply frame built from the latched requester fields.
  // ************************************************************
  assign eth = '{dst_mac: req_sha, src_mac: dev.mac, ethertype: `ARP_ETHERTYPE};

  assign rep = '{htype: `ARP_HTYPE_ETH,
                 ptype: `ARP_PTYPE_IPV4,
                 hlen:  `ARP_HLEN_MAC,
                 plen:  `ARP_PLEN_IPV4,
                 oper:  `ARP_OPER_REPLY,
                 sha:   dev.mac,
                 spa:   dev.ipv4,
                 tha:   req_sha,
                 tpa:   req_spa};

  // the first byte on the wire sits in the top entry.
  assign frame = {eth, rep};

  assign busy = (state == arp_pkg::TS_SEND);
  assign xfer = busy && tx_rdy;
  assign last = (idx == 6'(LAST));

  assign tx = '{dat: frame[6'(LAST) - idx], val: busy, err: 1'b0};

  assign reply_pulse = xfer && last;
  assign drop_pulse  = req_pulse && busy;

  // ************************************************************
  // send state machine.
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= arp_pkg::TS_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        arp_pkg::TS_IDLE: begin
          if (req_pulse) begin
            state <= arp_pkg::TS_SEND;
            idx   <= '0;
          end
        end
        default: begin
          if (xfer) begin
            if (last) begin
              state <= arp_pkg::TS_IDLE;
              idx   <= '0;
            end else begin
              idx <= idx + 6'd1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_pulse && !busy) begin
      req_sha <= req_hdr.sha;
      req_spa <= req_hdr.spa;
    end
  end

endmodule

/* hdl/arp_rx.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module arp_rx (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::byte_strm_t pay,
  input  arp_pkg::eth_meta_t  meta,
  input  arp_pkg::dev_t       dev,
  output arp_pkg::arp_hdr_t   req_hdr,
  output logic                req_pulse
);

  // largest payload that still fits in a minimum size frame.
  localparam int PAY_MAX  = `ETH_FRAME_MAX - `ETH_HDR_BYTES;
  localparam int HDR_BITS = $bits(arp_pkg::arp_hdr_t);

  logic [HDR_BITS-1:0] shreg;
  arp_pkg::arp_hdr_t   cur;
  logic [5:0]          pay_cnt;
  logic                in_frm;
  logic                bad;
  logic                fields_ok;
  logic                len_ok;

  assign cur = shreg;

  // the first 28 payload bytes are kept, anything after is pad.
  always_ff @(posedge clk) begin
    if (pay.val && pay_cnt < 6'(`ARP_HDR_BYTES)) begin
      shreg <= {shreg[HDR_BITS-9:0], pay.dat};
    end
  end

  // ************************************************************
  // decision logic.
  // ************************************************************
  assign fields_ok = (meta.ethertype == `ARP_ETHERTYPE) &&
                     (cur.htype == `ARP_HTYPE_ETH) &&
                     (cur.ptype == `ARP_PTYPE_IPV4) &&
                     (cur.hlen == `ARP_HLEN_MAC) &&
                     (cur.plen == `ARP_PLEN_IPV4) &&
                     (cur.oper == `ARP_OPER_REQ) &&
                     (cur.tpa == dev.ipv4);

  assign len_ok = (pay_cnt >= 6'(`ARP_HDR_BYTES));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pay_cnt   <= '0;
      in_frm    <= 1'b0;
      bad       <= 1'b0;
      req_pulse <= 1'b0;
    end else begin
      req_pulse <= 1'b0;
      if (pay.val) begin
        in_frm <= 1'b1;
        if (pay_cnt != 6'(PAY_MAX)) pay_cnt <= pay_cnt + 6'd1;
        if (pay.err || pay_cnt == 6'(PAY_MAX)) bad <= 1'b1;
      end else begin
        // an idle cycle ends the frame and clears everything for the next.
        in_frm  <= 1'b0;
        pay_cnt <= '0;
        bad     <= 1'b0;
        if (in_frm && !bad && len_ok && fields_ok) req_pulse <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!pay.val && in_frm) req_hdr <= cur;
  end

endmodule

/* hdl/eth_rx_parser.sv */
`timescale 1ns/10ps

`include "arp_macros.svh"

module eth_rx_parser (
  input  logic                clk,
  input  logic                fsm_rst,
  input  arp_pkg::byte_strm_t rx,
  output arp_pkg::byte_strm_t pay,
  output arp_pkg::eth_meta_t  meta
);

  localparam int META_BITS = $bits(arp_pkg::eth_meta_t);

  arp_pkg::parse_state_t state;
  logic [3:0]            hdr_cnt;
  logic [7:0]            pay_dat;
  logic                  pay_val;
  logic                  pay_err;
  logic [META_BITS-1:0]  meta_q;

  // ************************************************************
  // header counter and frame state.
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= arp_pkg::PS_HDR;
      hdr_cnt <= '0;
    end else begin
      case (state)
        arp_pkg::PS_HDR: begin
          if (!rx.val) begin
            hdr_cnt <= '0;
          end else if (rx.err) begin
            state   <= arp_pkg::PS_DISCARD;
            hdr_cnt <= '0;
          end else if (hdr_cnt == 4'(`ETH_HDR_BYTES - 1)) begin
            state   <= arp_pkg::PS_PAYLOAD;
            hdr_cnt <= '0;
          end else begin
            hdr_cnt <= hdr_cnt + 4'd1;
          end
        end
        arp_pkg::PS_PAYLOAD: begin
          if (!rx.val) state <= arp_pkg::PS_HDR;
          else if (rx.err) state <= arp_pkg::PS_DISCARD;
        end
        default: begin
          // wait for the aborted frame to go idle.
          if (!rx.val) state <= arp_pkg::PS_HDR;
          hdr_cnt <= '0;
        end
      endcase
    end
  end

  // header bytes enter at the bottom so the first one ends up in the msbs.
  always_ff @(posedge clk) begin
    if (state == arp_pkg::PS_HDR && rx.val && !rx.err) begin
      meta_q <= {meta_q[META_BITS-9:0], rx.dat};
    end
  end

  // ************************************************************
  // registered payload stream.
  // ************************************************************
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pay_val <= 1'b0;
      pay_err <= 1'b0;
    end else begin
      pay_val <= rx.val && (state == arp_pkg::PS_PAYLOAD);
      pay_err <= rx.val && rx.err && (state != arp_pkg::PS_DISCARD);
    end
  end

  always_ff @(posedge clk) begin
    pay_dat <= rx.dat;
  end

  assign pay  = '{dat: pay_dat, val: pay_val, err: pay_err};
  assign meta = meta_q;

endmodule

/* hdl/arp_pkg.sv */
package arp_pkg;

  // ************************************************************
  // vectors with a meaning of their own.
  // ************************************************************
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [15:0] cnt_t;

  // one beat of a byte stream.
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       err;
  } byte_strm_t;

  typedef struct packed {
    mac_addr_t  dst_mac;
    mac_addr_t  src_mac;
    ethertype_t ethertype;
  } eth_meta_t;

  // fields in the order they appear on the wire, first byte in the msbs.
  typedef struct packed {
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_addr_t   sha;
    ipv4_addr_t  spa;
    mac_addr_t   tha;
    ipv4_addr_t  tpa;
  } arp_hdr_t;

  typedef struct packed {
    mac_addr_t  mac;
    ipv4_addr_t ipv4;
  } dev_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {PS_HDR, PS_PAYLOAD, PS_DISCARD} parse_state_t;
  typedef enum logic {TS_IDLE, TS_SEND} tx_state_t;

endpackage

/* hdl/arp_macros.svh */
`ifndef ARP_MACROS_SVH
`define ARP_MACROS_SVH

// ************************************************************
// protocol field values.
// ************************************************************
`define ARP_ETHERTYPE   16'h0806
`define ARP_HTYPE_ETH   16'h0001
`define ARP_PTYPE_IPV4  16'h0800
`define ARP_HLEN_MAC    8'd6
`define ARP_PLEN_IPV4   8'd4
`define ARP_OPER_REQ    16'd1
`define ARP_OPER_REPLY  16'd2

// frame lengths in bytes, without preamble and fcs.
`define ETH_HDR_BYTES   14
`define ARP_HDR_BYTES   28
`define ETH_FRAME_MAX   60
`define ARP_REPLY_BYTES 42

// register map, word addresses.
`define REG_IPV4      3'd0
`define REG_MAC_HI    3'd1
`define REG_MAC_LO    3'd2
`define REG_REQ_CNT   3'd3
`define REG_REPLY_CNT 3'd4
`define REG_DROP_CNT  3'd5

`endif
